/* vga_macros.svh */
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The 640x480 at 60 Hz raster timing is counted in pixels and lines.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)

`define H_BITS 10 // Wide enough for 0..799.
`define V_BITS 10 // Wide enough for 0..524.

// Sprite placement and size.
`define SPRITE_X0 81
`define SPRITE_Y0 100
`define SPRITE_W 59
`define SPRITE_H 112

`define COLOR_BITS 4

`endif

/* vga_pkg.sv */
`default_nettype none

`include "vga_macros.svh"

package vga_pkg;

  localparam int SPRITE_COL_BITS = $clog2(`SPRITE_W);
  localparam int SPRITE_ROW_BITS = $clog2(`SPRITE_H);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sprite bitmap. Entry 0 is the top row, bit 0 the left column.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [`SPRITE_W-1:0] sprite_bitmap [`SPRITE_H] = '{
    59'b00000000000000000000000000000000000000000000000000010000000,
    59'b00000000000000000000000000000000000000000000000000111000000,
    59'b00000000000000000000000000000000000000000000000000111110000,
    59'b00000000000000000000000000000000000000000000000001111111000,
    59'b00000000000000000000000000000000000000000000000011111111100,
    59'b00000000000000000000000000000000000000000000000111111111110,
    59'b00000000000000000000000000000000000000000000000111111111110,
    59'b00000000000000000000000000000000000000000000001111111111100,
    59'b00000000000000000000000000000000000000000000011111111111100,
    59'b00000000000000000000000000000000000000000000011111111111000,
    59'b00000000000000000000000000000000000000000000111111111110000,
    59'b00000000000000000000000000000000000000000001111111111110000,
    59'b00000000000000000000000000000000000000000001111111111100000,
    59'b00000000000000000000000000000000000000000011111111111100000,
    59'b00000000000000000000000000000000000000000011111111111000000,
    59'b00000000000000000000000000000000000000000111111111110000000,
    59'b00000000000000000000000000000000000000000111111111110000000,
    59'b00000000000000000000000000000000000000001111111111100000000,
    59'b00000000000000000000000000000000000000001111111111100000000,
    59'b00000000000000000000000000000000000000011111111111000000000,
    59'b00000000000000000000000000000000000000011111111111000000000,
    59'b00000000000000000000000000000000000000111111111111000000000,
    59'b00000000000000000000000000000000000000111111111110000000000,
    59'b00000000000000000000000000000000000001111111111110000000000,
    59'b00000000000000000000000000000000000001111111111100000000000,
    59'b00000000000000000000000000000000000001111111111100000000000,
    59'b00000000000000000000000000000000000011111111111100000000000,
    59'b00000111111100000000000000000000000011111111111000000000000,
    59'b00011111111111000000000000000000000011111111111000000000000,
    59'b00111111111111100000000000000000000111111111111000000000000,
    59'b01111111111111110000000000000000000111111111110000000000000,
    59'b11111111111111111000000000000000000111111111110000000000000,
    59'b11111111111111111000000000000000000111111111110000000000000,
    59'b11111111111111111000000000000000001111111111110000000000000,
    59'b11111111111111111100000000000000001111111111100000000000000,
    59'b11111111111111111100000000000000001111111111100000000000000,
    59'b11111111111111111100000000000000001111111111100000000000000,
    59'b11111111111111111000000000000000001111111111100000000000000,
    59'b11111111111111111000000000000000001111111111100000000000000,
    59'b01111111111111111000000000000000011111111111000000000000000,
    59'b01111111111111110000000000000000011111111111000000000000000,
    59'b00111111111111100000000000000000011111111111000000000000000,
    59'b00011111111111000000000000000000011111111111000000000000000,
    59'b00000111111100000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000111111111110000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111000000000000000,
    59'b00000000000000000000000000000000011111111111100000000000000,
    59'b00000000000000000000000000000000001111111111100000000000000,
    59'b00000000000000000000000000000000001111111111100000000000000,
    59'b00000001110000000000000000000000001111111111100000000000000,
    59'b00001111111110000000000000000000001111111111100000000000000,
    59'b00011111111111100000000000000000001111111111110000000000000,
    59'b00111111111111110000000000000000000111111111110000000000000,
    59'b01111111111111110000000000000000000111111111110000000000000,
    59'b11111111111111111000000000000000000111111111111000000000000,
    59'b11111111111111111000000000000000000111111111111000000000000,
    59'b11111111111111111000000000000000000011111111111000000000000,
    59'b11111111111111111100000000000000000011111111111100000000000,
    59'b11111111111111111100000000000000000011111111111100000000000,
    59'b11111111111111111000000000000000000001111111111100000000000,
    59'b11111111111111111000000000000000000001111111111110000000000,
    59'b11111111111111111000000000000000000001111111111110000000000,
    59'b01111111111111110000000000000000000000111111111110000000000,
    59'b00111111111111110000000000000000000000111111111111000000000,
    59'b00111111111111100000000000000000000000111111111111000000000,
    59'b00001111111110000000000000000000000000011111111111100000000,
    59'b00000011111000000000000000000000000000011111111111100000000,
    59'b00000000000000000000000000000000000000001111111111110000000,
    59'b00000000000000000000000000000000000000001111111111110000000,
    59'b00000000000000000000000000000000000000000111111111111000000,
    59'b00000000000000000000000000000000000000000111111111111000000,
    59'b00000000000000000000000000000000000000000011111111111100000,
    59'b00000000000000000000000000000000000000000001111111111110000,
    59'b00000000000000000000000000000000000000000001111111111110000,
    59'b00000000000000000000000000000000000000000000111111111111000,
    59'b00000000000000000000000000000000000000000000111111111111000,
    59'b00000000000000000000000000000000000000000000011111111111100,
    59'b00000000000000000000000000000000000000000000001111111111110,
    59'b00000000000000000000000000000000000000000000000111111111110,
    59'b00000000000000000000000000000000000000000000000111111111111,
    59'b00000000000000000000000000000000000000000000000011111111110,
    59'b00000000000000000000000000000000000000000000000001111111100,
    59'b00000000000000000000000000000000000000000000000000111111000,
    59'b00000000000000000000000000000000000000000000000000011110000,
    59'b00000000000000000000000000000000000000000000000000011000000
  };

  // True when the position lies in the sprite box and its bitmap bit is set.
  function automatic logic sprite_pixel(
    input logic [`H_BITS-1:0] h_pos,
    input logic [`V_BITS-1:0] v_pos
  );
    logic [`H_BITS-1:0] dx;
    logic [`V_BITS-1:0] dy;
    logic in_x;
    logic in_y;
    dx = h_pos - `H_BITS'(`SPRITE_X0);
    dy = v_pos - `V_BITS'(`SPRITE_Y0);
    // Positions left of or above the origin wrap to large offsets.
    in_x = (h_pos >= `H_BITS'(`SPRITE_X0)) && (dx < `H_BITS'(`SPRITE_W));
    in_y = (v_pos >= `V_BITS'(`SPRITE_Y0)) && (dy < `V_BITS'(`SPRITE_H));
    if (in_x && in_y) begin
      return sprite_bitmap[dy[SPRITE_ROW_BITS-1:0]][dx[SPRITE_COL_BITS-1:0]];
    end
    return 1'b0;
  endfunction

endpackage

`default_nettype wire

/* video_timing_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_macros.svh"

// Raster position plus decoded blank and sync are valid every clock.
interface video_timing_if;

  logic [`H_BITS-1:0] h_pos;
  logic [`V_BITS-1:0] v_pos;
  logic blank; // High outside the visible area.
  logic h_sync; // Active high.
  logic v_sync; // Active high.

  modport source (
    output h_pos, v_pos, blank, h_sync, v_sync
  );

  modport sink (
    input h_pos, v_pos, blank, h_sync, v_sync
  );

endinterface

`default_nettype wire

/* vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_macros.svh"

module vga_timing (
  input logic clk,
  input logic rst,
  video_timing_if.source tim
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Segment boundaries.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [`H_BITS-1:0] H_LAST = `H_BITS'(`H_TOTAL - 1);
  localparam logic [`H_BITS-1:0] H_ACTIVE_END = `H_BITS'(`H_VISIBLE);
  localparam logic [`H_BITS-1:0] H_SYNC_START = `H_BITS'(`H_VISIBLE + `H_FRONT);
  localparam logic [`H_BITS-1:0] H_SYNC_END = `H_BITS'(`H_VISIBLE + `H_FRONT + `H_SYNC);

  localparam logic [`V_BITS-1:0] V_LAST = `V_BITS'(`V_TOTAL - 1);
  localparam logic [`V_BITS-1:0] V_ACTIVE_END = `V_BITS'(`V_VISIBLE);
  localparam logic [`V_BITS-1:0] V_SYNC_START = `V_BITS'(`V_VISIBLE + `V_FRONT);
  localparam logic [`V_BITS-1:0] V_SYNC_END = `V_BITS'(`V_VISIBLE + `V_FRONT + `V_SYNC);

  logic [`H_BITS-1:0] h_cnt;
  logic [`V_BITS-1:0] v_cnt;
  logic line_end;

  assign line_end = (h_cnt == H_LAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // The line counter advances once per horizontal wrap.
  always_ff @(posedge clk) begin
    if (rst) begin
      v_cnt <= '0;
    end else if (line_end) begin
      if (v_cnt == V_LAST) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end
  end

  assign tim.h_pos = h_cnt;
  assign tim.v_pos = v_cnt;
  assign tim.blank = (h_cnt >= H_ACTIVE_END) || (v_cnt >= V_ACTIVE_END);
  assign tim.h_sync = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
  assign tim.v_sync = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);

endmodule

`default_nettype wire

/* sprite_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_macros.svh"

module sprite_renderer (
  input logic clk,
  input logic rst,
  video_timing_if.sink tim,
  output logic [`COLOR_BITS-1:0] red,
  output logic [`COLOR_BITS-1:0] green,
  output logic [`COLOR_BITS-1:0] blue,
  output logic hsync_n,
  output logic vsync_n
);

  import vga_pkg::*;

  localparam logic [`COLOR_BITS-1:0] FULL = '1;
  localparam logic [`COLOR_BITS-1:0] OFF = '0;

  logic sprite_on;

  assign sprite_on = sprite_pixel(tim.h_pos, tim.v_pos);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pixel stage. Colour and sync share one register delay.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      red <= OFF;
      green <= OFF;
      blue <= OFF;
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
    end else begin
      hsync_n <= ~tim.h_sync; // Negative polarity at the pins.
      vsync_n <= ~tim.v_sync;
      if (tim.blank) begin
        red <= OFF;
        green <= OFF;
        blue <= OFF;
      end else if (sprite_on) begin
        red <= FULL;
        green <= FULL;
        blue <= FULL;
      end else begin
        // Background is pure blue.
        red <= OFF;
        green <= OFF;
        blue <= FULL;
      end
    end
  end

endmodule

`default_nettype wire

/* vga_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_macros.svh"

module vga_top (
  input logic clk,
  input logic rst,
  output logic [`COLOR_BITS-1:0] red,
  output logic [`COLOR_BITS-1:0] green,
  output logic [`COLOR_BITS-1:0] blue,
  output logic hsync_n,
  output logic vsync_n
);

  video_timing_if tim ();

  // Raster counters and sync decode.
  vga_timing u_vga_timing (
    .clk (clk),
    .rst (rst),
    .tim (tim.source)
  );

  // One clock behind the counters.
  sprite_renderer u_sprite_renderer (
    .clk (clk),
    .rst (rst),
    .tim (tim.sink),
    .red (red),
    .green (green),
    .blue (blue),
    .hsync_n (hsync_n),
    .vsync_n (vsync_n)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period.
  end

  // The power-on reset is released just after a rising edge.
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

/* tb_vga_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vga_macros.svh"

module tb_vga_top;

  import vga_pkg::*;

  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int H_SYNC_FIRST = `H_VISIBLE + `H_FRONT;
  localparam int V_SYNC_FIRST = `V_VISIBLE + `V_FRONT;
  localparam int WATCHDOG_CYCLES = 16 + 4 * FRAME_CYCLES + 16 + 1000;

  logic clk;
  logic por_rst;
  logic mid_rst;
  logic rst;
  logic [`COLOR_BITS-1:0] red;
  logic [`COLOR_BITS-1:0] green;
  logic [`COLOR_BITS-1:0] blue;
  logic hsync_n;
  logic vsync_n;

  // Model state and the prediction for the next rising edge.
  int m_h = 0;
  int m_v = 0;
  int exp_h;
  int exp_v;
  int exp_red;
  int exp_green;
  int exp_blue;
  int exp_hsync_n;
  int exp_vsync_n;
  logic exp_rst;
  string exp_kind;
  logic have_exp = 1'b0;
  logic prev_hsync_n = 1'b1;
  logic prev_vsync_n = 1'b1;
  int hs_len = 0;
  int errors = 0;
  logic [31:0] lfsr_state = 32'h9ee2;

  assign rst = por_rst | mid_rst;

  tb_clock_gen u_clock_gen (
    .clk (clk),
    .rst (por_rst)
  );

  vga_top u_vga_top (
    .clk (clk),
    .rst (rst),
    .red (red),
    .green (green),
    .blue (blue),
    .hsync_n (hsync_n),
    .vsync_n (vsync_n)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic sprite_bit_at(input int h, input int v);
    logic [6:0] row;
    logic [5:0] col;
    logic [`SPRITE_W-1:0] line;
    if (h < `SPRITE_X0 || h >= `SPRITE_X0 + `SPRITE_W) begin
      return 1'b0;
    end
    if (v < `SPRITE_Y0 || v >= `SPRITE_Y0 + `SPRITE_H) begin
      return 1'b0;
    end
    row = 7'(v - `SPRITE_Y0);
    col = 6'(h - `SPRITE_X0);
    line = sprite_bitmap[row];
    return line[col];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors = errors + 1;
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  // Predicts the outputs of the next edge from the model position, then steps it.
  task automatic predict(input logic rst_now);
    logic visible;
    exp_rst = rst_now;
    exp_h = m_h;
    exp_v = m_v;
    if (rst_now) begin
      exp_kind = "reset";
      exp_red = 0;
      exp_green = 0;
      exp_blue = 0;
      exp_hsync_n = 1;
      exp_vsync_n = 1;
      m_h = 0;
      m_v = 0;
    end else begin
      visible = (m_h < `H_VISIBLE) && (m_v < `V_VISIBLE);
      exp_hsync_n = (m_h >= H_SYNC_FIRST && m_h < H_SYNC_FIRST + `H_SYNC) ? 0 : 1;
      exp_vsync_n = (m_v >= V_SYNC_FIRST && m_v < V_SYNC_FIRST + `V_SYNC) ? 0 : 1;
      if (!visible) begin
        exp_kind = "blank";
        exp_red = 0;
        exp_green = 0;
        exp_blue = 0;
      end else if (sprite_bit_at(m_h, m_v)) begin
        exp_kind = "sprite";
        exp_red = 15;
        exp_green = 15;
        exp_blue = 15;
      end else begin
        exp_kind = "background";
        exp_red = 0;
        exp_green = 0;
        exp_blue = 15;
      end
      if (m_h == `H_TOTAL - 1) begin
        m_h = 0;
        if (m_v == `V_TOTAL - 1) begin
          m_v = 0;
        end else begin
          m_v = m_v + 1;
        end
      end else begin
        m_h = m_h + 1;
      end
    end
  endtask

  task automatic compare_outputs();
    check_value({exp_kind, "_red"}, 32'(exp_red), 32'(red));
    check_value({exp_kind, "_green"}, 32'(exp_green), 32'(green));
    check_value({exp_kind, "_blue"}, 32'(exp_blue), 32'(blue));
    check_value("hsync", 32'(exp_hsync_n), 32'(hsync_n));
    check_value("vsync", 32'(exp_vsync_n), 32'(vsync_n));
    if (exp_rst) begin
      hs_len = 0;
    end else begin
      if (!hsync_n) begin
        if (prev_hsync_n) begin
          check_value("hsync_start_pixel", 32'(H_SYNC_FIRST), 32'(exp_h));
          hs_len = 0;
        end
        hs_len = hs_len + 1;
      end else if (!prev_hsync_n) begin
        check_value("hsync_width", 32'(`H_SYNC), 32'(hs_len));
      end
      if (!vsync_n && prev_vsync_n) begin
        check_value("vsync_start_line", 32'(V_SYNC_FIRST), 32'(exp_v));
        check_value("vsync_start_pixel", 32'd0, 32'(exp_h));
      end else if (vsync_n && !prev_vsync_n) begin
        check_value("vsync_end_line", 32'(V_SYNC_FIRST + `V_SYNC), 32'(exp_v));
      end
    end
    prev_hsync_n = hsync_n;
    prev_vsync_n = vsync_n;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Processes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Outputs are checked mid-cycle, when they are stable.
  initial begin
    forever begin
      @(negedge clk);
      if (have_exp) begin
        compare_outputs();
      end
      predict(rst); // Reset here is the value the next edge will see.
      have_exp = 1'b1;
    end
  end

  initial begin
    int start_at;
    int hold;
    mid_rst = 1'b0;
    @(negedge por_rst);
    repeat (2 * FRAME_CYCLES) @(posedge clk);
    draw_bits(19, start_at);
    start_at = start_at % FRAME_CYCLES;
    draw_bits(4, hold);
    hold = hold + 1;
    repeat (start_at) @(posedge clk);
    #1 mid_rst = 1'b1;
    repeat (hold) @(posedge clk);
    #1 mid_rst = 1'b0;
    repeat (FRAME_CYCLES) @(posedge clk);
    @(negedge clk);
    #1;
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Watchdog timeout: the simulation ran longer than the tests allow.");
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired.");
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
vga_pkg.sv
video_timing_if.sv
vga_timing.sv
sprite_renderer.sv
vga_top.sv
tb_clock_gen.sv
tb_vga_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the VGA testbench with Verilator, runs it and judges the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_vga_top -o tb_vga_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status."
  exit 1
fi

./obj_dir/tb_vga_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status."
fi

# The log decides the result.
if grep -q "^ALL TESTS PASSED$" "$LOG"; then
  echo "Result: pass."
  exit 0
else
  echo "Result: fail."
  exit 1
fi
